// ==== priv_consts.svh ====
`ifndef PRIV_CONSTS_SVH
`define PRIV_CONSTS_SVH

// privilege modes
`define PRIV_M 2'd3
`define PRIV_U 2'd0

// machine csr addresses
`define CSR_MSTATUS  12'h300
`define CSR_MISA     12'h301
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVAL    12'h343
`define CSR_MIP      12'h344
`define CSR_MCYCLE   12'hb00
`define CSR_MCYCLEH  12'hb80
`define CSR_MHARTID  12'hf14

// writable bits and mstatus fields
`define MSTATUS_MASK 32'h0000_1888
`define MIE_MASK     32'h0000_0888
`define MST_MIE      3
`define MST_MPIE     7

// rv32 with a, i, m and user mode
`define MISA_VALUE  32'h4010_1101
`define RESET_MTVEC 32'h0000_0100

// mcause codes
`define CAUSE_ILLEGAL 5'd2
`define CAUSE_BREAK   5'd3
`define CAUSE_ECALL_U 5'd8
`define CAUSE_ECALL_M 5'd11
`define IRQ_SOFT      5'd3
`define IRQ_TIMER     5'd7
`define IRQ_EXT       5'd11

// system opcode, funct12 values, csr operations
`define OPC_SYSTEM   7'h73
`define F12_ECALL    12'h000
`define F12_EBREAK   12'h001
`define F12_WFI      12'h105
`define F12_MRET     12'h302
`define CSR_FN_WRITE 2'd1
`define CSR_FN_SET   2'd2
`define CSR_FN_CLEAR 2'd3

`endif

// ==== priv_pkg.sv ====
package priv_pkg;

   ////////////////////////////////////////
   // system instruction word
   ////////////////////////////////////////

   // i-type layout shared by csr and trap-return words
   typedef struct packed {
      logic [11:0] csr;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } sys_fields_s;

   // one word, seen whole or split into fields
   typedef union packed {
      logic [31:0] raw;
      sys_fields_s fields;
   } sys_instr_u;

endpackage

// ==== sys_decoder.sv ====
`timescale 1ns/10ps
`include "priv_consts.svh"

module sys_decoder (
   input  priv_pkg::sys_instr_u instr,
   output logic                 is_csr,
   output logic                 csr_use_imm,
   output logic [1:0]           csr_funct,
   output logic                 csr_wr,
   output logic                 is_ecall,
   output logic                 is_ebreak,
   output logic                 is_mret,
   output logic                 is_wfi,
   output logic                 is_illegal
);

   always_comb begin
      is_csr     = 1'b0;
      is_ecall   = 1'b0;
      is_ebreak  = 1'b0;
      is_mret    = 1'b0;
      is_wfi     = 1'b0;
      is_illegal = 1'b1;
      csr_use_imm = instr.fields.funct3[2];
      csr_funct   = instr.fields.funct3[1:0];
      if (instr.fields.opcode == `OPC_SYSTEM) begin
         if (instr.fields.funct3 == 3'b000) begin
            // trap and return words need rs1 and rd at zero
            if (instr.fields.rs1 == 5'd0 && instr.fields.rd == 5'd0) begin
               is_illegal = 1'b0;
               case (instr.fields.csr)
                  `F12_ECALL:  is_ecall = 1'b1;
                  `F12_EBREAK: is_ebreak = 1'b1;
                  `F12_MRET:   is_mret = 1'b1;
                  `F12_WFI:    is_wfi = 1'b1;
                  default:     is_illegal = 1'b1;
               endcase
            end
         end else if (instr.fields.funct3[1:0] != 2'b00) begin
            is_csr     = 1'b1;
            is_illegal = 1'b0;
         end
      end
      // set/clear with a zero source only reads
      csr_wr = is_csr && (csr_funct == `CSR_FN_WRITE || instr.fields.rs1 != 5'd0);
   end

endmodule

// ==== csr_file.sv ====
`timescale 1ns/10ps
`include "priv_consts.svh"

module csr_file (
   input  logic        clk,
   input  logic        rstn,
   input  logic [11:0] csr_addr,
   input  logic        csr_we,
   input  logic [31:0] csr_wdata,
   input  logic        trap_enter,
   input  logic [31:0] trap_cause,
   input  logic [31:0] trap_epc,
   input  logic [31:0] trap_tval,
   input  logic [1:0]  trap_mode,
   input  logic        mret_exec,
   input  logic        ext_intr,
   input  logic        software_intr,
   input  logic        timer_intr,
   output logic [31:0] csr_rdata,
   output logic        csr_exists,
   output logic        csr_writable,
   output logic        mstatus_mie,
   output logic [1:0]  mstatus_mpp,
   output logic [31:0] mtvec,
   output logic [31:0] mepc,
   output logic        irq_present,
   output logic [4:0]  irq_code
);

   logic [31:0] mstatus_q, mie_q, mtvec_q, mscratch_q, mepc_q, mcause_q, mtval_q;
   logic [63:0] mcycle_q;
   logic [31:0] mip_val, irq_pend, mstatus_wr;

   assign mip_val = {20'd0, ext_intr, 3'd0, timer_intr, 3'd0, software_intr, 3'd0};
   assign irq_pend = mip_val & mie_q;

   assign mstatus_mie = mstatus_q[`MST_MIE];
   assign mstatus_mpp = mstatus_q[12:11];
   assign mtvec       = mtvec_q;
   assign mepc        = mepc_q;

   ////////////////////////////////////////
   // read path
   ////////////////////////////////////////
   always_comb begin
      csr_rdata  = 32'd0;
      csr_exists = 1'b1;
      case (csr_addr)
         `CSR_MSTATUS:  csr_rdata = mstatus_q;
         `CSR_MISA:     csr_rdata = `MISA_VALUE;
         `CSR_MIE:      csr_rdata = mie_q;
         `CSR_MTVEC:    csr_rdata = mtvec_q;
         `CSR_MSCRATCH: csr_rdata = mscratch_q;
         `CSR_MEPC:     csr_rdata = mepc_q;
         `CSR_MCAUSE:   csr_rdata = mcause_q;
         `CSR_MTVAL:    csr_rdata = mtval_q;
         `CSR_MIP:      csr_rdata = mip_val;
         `CSR_MCYCLE:   csr_rdata = mcycle_q[31:0];
         `CSR_MCYCLEH:  csr_rdata = mcycle_q[63:32];
         // single hart, id 0
         `CSR_MHARTID:  csr_rdata = 32'd0;
         default:       csr_exists = 1'b0;
      endcase
   end

   assign csr_writable = csr_exists &&
                         !(csr_addr == `CSR_MISA || csr_addr == `CSR_MIP ||
                           csr_addr == `CSR_MCYCLEH || csr_addr == `CSR_MHARTID);

   // ext first, then software, then timer
   always_comb begin
      irq_present = |irq_pend;
      irq_code    = 5'd0;
      if (irq_pend[11]) begin
         irq_code = `IRQ_EXT;
      end else if (irq_pend[3]) begin
         irq_code = `IRQ_SOFT;
      end else if (irq_pend[7]) begin
         irq_code = `IRQ_TIMER;
      end
   end

   // mpp only holds M or U
   always_comb begin
      mstatus_wr = csr_wdata & `MSTATUS_MASK;
      if (mstatus_wr[12:11] == 2'd1 || mstatus_wr[12:11] == 2'd2) begin
         mstatus_wr[12:11] = `PRIV_U;
      end
   end

   ////////////////////////////////////////
   // write path and side-effects
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rstn) begin
         mstatus_q  <= 32'd0;
         mie_q      <= 32'd0;
         mtvec_q    <= `RESET_MTVEC;
         mscratch_q <= 32'd0;
         mepc_q     <= 32'd0;
         mcause_q   <= 32'd0;
         mtval_q    <= 32'd0;
         mcycle_q   <= 64'd0;
      end else begin
         mcycle_q <= mcycle_q + 64'd1;
         if (trap_enter) begin
            mepc_q   <= trap_epc;
            mcause_q <= trap_cause;
            mtval_q  <= trap_tval;
            mstatus_q[`MST_MPIE] <= mstatus_q[`MST_MIE];
            mstatus_q[`MST_MIE]  <= 1'b0;
            mstatus_q[12:11]     <= trap_mode;
         end else if (mret_exec) begin
            mstatus_q[`MST_MIE]  <= mstatus_q[`MST_MPIE];
            mstatus_q[`MST_MPIE] <= 1'b1;
            mstatus_q[12:11]     <= `PRIV_U;
         end else if (csr_we) begin
            case (csr_addr)
               `CSR_MSTATUS:  mstatus_q <= mstatus_wr;
               `CSR_MIE:      mie_q <= csr_wdata & `MIE_MASK;
               `CSR_MSCRATCH: mscratch_q <= csr_wdata;
               `CSR_MEPC:     mepc_q <= {csr_wdata[31:2], 2'b00};
               `CSR_MCAUSE:   mcause_q <= csr_wdata;
               `CSR_MTVAL:    mtval_q <= csr_wdata;
               `CSR_MCYCLE:   mcycle_q <= {mcycle_q[63:32], csr_wdata};
               `CSR_MTVEC: begin
                  // reserved modes leave mtvec alone
                  if (csr_wdata[1:0] < 2'd2) begin
                     mtvec_q <= csr_wdata;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   a_mtvec_mode: assert property (@(posedge clk) disable iff (rstn) mtvec_q[1:0] < 2'd2);

endmodule

// ==== priv_ctrl.sv ====
`timescale 1ns/10ps
`include "priv_consts.svh"

module priv_ctrl (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 instr_valid,
   input  priv_pkg::sys_instr_u instr,
   input  logic [31:0]          pc,
   input  logic [31:0]          rs1_value,
   input  logic                 is_csr,
   input  logic                 csr_use_imm,
   input  logic [1:0]           csr_funct,
   input  logic                 csr_wr,
   input  logic                 is_ecall,
   input  logic                 is_ebreak,
   input  logic                 is_mret,
   input  logic                 is_wfi,
   input  logic                 is_illegal,
   input  logic [31:0]          csr_rdata,
   input  logic                 csr_exists,
   input  logic                 csr_writable,
   input  logic                 mstatus_mie,
   input  logic [1:0]           mstatus_mpp,
   input  logic [31:0]          mtvec,
   input  logic [31:0]          mepc,
   input  logic                 irq_present,
   input  logic [4:0]           irq_code,
   output logic [11:0]          csr_addr,
   output logic                 csr_we,
   output logic [31:0]          csr_wdata,
   output logic                 trap_enter,
   output logic [31:0]          trap_cause,
   output logic [31:0]          trap_epc,
   output logic [31:0]          trap_tval,
   output logic [1:0]           trap_mode,
   output logic                 mret_exec,
   output logic                 done,
   output logic                 trap_taken,
   output logic [31:0]          next_pc,
   output logic [31:0]          rd_data,
   output logic                 write_rd,
   output logic [1:0]           priv_mode
);

   logic        irq_take, illegal, exc, csr_ok;
   logic [4:0]  exc_code;
   logic [31:0] src, tvec_base, next_pc_d;

   assign csr_addr = instr.raw[31:20];
   assign src = csr_use_imm ? {27'd0, instr.raw[19:15]} : rs1_value;

   always_comb begin
      // interrupts win over the instruction itself
      irq_take = instr_valid && irq_present && (priv_mode == `PRIV_U || mstatus_mie);
      illegal  = is_illegal ||
                 (is_csr && !csr_exists) ||
                 (is_csr && csr_wr && !csr_writable) ||
                 (is_csr && priv_mode == `PRIV_U) ||
                 (is_mret && priv_mode == `PRIV_U);
      exc = instr_valid && !irq_take && (illegal || is_ecall || is_ebreak);
      if (illegal) begin
         exc_code = `CAUSE_ILLEGAL;
      end else if (is_ebreak) begin
         exc_code = `CAUSE_BREAK;
      end else begin
         exc_code = (priv_mode == `PRIV_U) ? `CAUSE_ECALL_U : `CAUSE_ECALL_M;
      end
      csr_ok    = instr_valid && !irq_take && !illegal && is_csr;
      mret_exec = instr_valid && !irq_take && !illegal && is_mret;
      case (csr_funct)
         `CSR_FN_SET:   csr_wdata = csr_rdata | src;
         `CSR_FN_CLEAR: csr_wdata = csr_rdata & ~src;
         default:       csr_wdata = src;
      endcase
      csr_we     = csr_ok && csr_wr;
      trap_enter = irq_take || exc;
      trap_cause = irq_take ? {1'b1, 26'd0, irq_code} : {27'd0, exc_code};
      trap_epc   = pc;
      trap_tval  = (exc && illegal) ? instr.raw : 32'd0;
      trap_mode  = priv_mode;
      tvec_base  = {mtvec[31:2], 2'b00};
      // wfi and csr ops fall through to pc + 4
      if (irq_take && mtvec[1:0] == 2'd1) begin
         next_pc_d = tvec_base + {25'd0, irq_code, 2'b00};
      end else if (trap_enter) begin
         next_pc_d = tvec_base;
      end else if (mret_exec) begin
         next_pc_d = mepc;
      end else begin
         next_pc_d = pc + 32'd4;
      end
   end

   ////////////////////////////////////////
   // result registers
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rstn) begin
         done       <= 1'b0;
         trap_taken <= 1'b0;
         write_rd   <= 1'b0;
         priv_mode  <= `PRIV_M;
      end else begin
         done       <= instr_valid;
         trap_taken <= trap_enter;
         write_rd   <= csr_ok && instr.raw[11:7] != 5'd0;
         if (trap_enter) begin
            priv_mode <= `PRIV_M;
         end else if (mret_exec) begin
            priv_mode <= mstatus_mpp;
         end
      end
   end

   always_ff @(posedge clk) begin
      next_pc <= next_pc_d;
      rd_data <= csr_ok ? csr_rdata : 32'd0;
   end

   a_done_after_valid: assert property (@(posedge clk) disable iff (rstn)
      done |-> $past(instr_valid));
   a_flags_need_done: assert property (@(posedge clk) disable iff (rstn)
      (trap_taken || write_rd) |-> done);

endmodule

// ==== priv_unit.sv ====
`timescale 1ns/10ps

module priv_unit (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 instr_valid,
   input  priv_pkg::sys_instr_u instr,
   input  logic [31:0]          pc,
   input  logic [31:0]          rs1_value,
   input  logic                 ext_intr,
   input  logic                 software_intr,
   input  logic                 timer_intr,
   output logic                 done,
   output logic                 trap_taken,
   output logic [31:0]          next_pc,
   output logic [31:0]          rd_data,
   output logic                 write_rd,
   output logic [1:0]           priv_mode
);

   // decoder to controller
   logic        is_csr, csr_use_imm, csr_wr, is_ecall, is_ebreak, is_mret, is_wfi, is_illegal;
   logic [1:0]  csr_funct;

   // controller and csr file
   logic [11:0] csr_addr;
   logic        csr_we, trap_enter, mret_exec, csr_exists, csr_writable;
   logic        mstatus_mie, irq_present;
   logic [31:0] csr_wdata, trap_cause, trap_epc, trap_tval, csr_rdata, mtvec, mepc;
   logic [1:0]  trap_mode, mstatus_mpp;
   logic [4:0]  irq_code;

   sys_decoder sys_decoder_inst (
      .instr(instr), .is_csr(is_csr), .csr_use_imm(csr_use_imm), .csr_funct(csr_funct),
      .csr_wr(csr_wr), .is_ecall(is_ecall), .is_ebreak(is_ebreak), .is_mret(is_mret),
      .is_wfi(is_wfi), .is_illegal(is_illegal)
   );

   csr_file csr_file_inst (
      .clk(clk), .rstn(rstn), .csr_addr(csr_addr), .csr_we(csr_we), .csr_wdata(csr_wdata),
      .trap_enter(trap_enter), .trap_cause(trap_cause), .trap_epc(trap_epc),
      .trap_tval(trap_tval), .trap_mode(trap_mode), .mret_exec(mret_exec),
      .ext_intr(ext_intr), .software_intr(software_intr), .timer_intr(timer_intr),
      .csr_rdata(csr_rdata), .csr_exists(csr_exists), .csr_writable(csr_writable),
      .mstatus_mie(mstatus_mie), .mstatus_mpp(mstatus_mpp), .mtvec(mtvec), .mepc(mepc),
      .irq_present(irq_present), .irq_code(irq_code)
   );

   priv_ctrl priv_ctrl_inst (
      .clk(clk), .rstn(rstn), .instr_valid(instr_valid), .instr(instr), .pc(pc),
      .rs1_value(rs1_value), .is_csr(is_csr), .csr_use_imm(csr_use_imm),
      .csr_funct(csr_funct), .csr_wr(csr_wr), .is_ecall(is_ecall), .is_ebreak(is_ebreak),
      .is_mret(is_mret), .is_wfi(is_wfi), .is_illegal(is_illegal), .csr_rdata(csr_rdata),
      .csr_exists(csr_exists), .csr_writable(csr_writable), .mstatus_mie(mstatus_mie),
      .mstatus_mpp(mstatus_mpp), .mtvec(mtvec), .mepc(mepc), .irq_present(irq_present),
      .irq_code(irq_code), .csr_addr(csr_addr), .csr_we(csr_we), .csr_wdata(csr_wdata),
      .trap_enter(trap_enter), .trap_cause(trap_cause), .trap_epc(trap_epc),
      .trap_tval(trap_tval), .trap_mode(trap_mode), .mret_exec(mret_exec), .done(done),
      .trap_taken(trap_taken), .next_pc(next_pc), .rd_data(rd_data), .write_rd(write_rd),
      .priv_mode(priv_mode)
   );

endmodule

// ==== tb_priv_unit.sv ====
`timescale 1ns/10ps

module tb_priv_unit;

   logic                 clk;
   logic                 rstn;
   logic                 instr_valid;
   priv_pkg::sys_instr_u instr;
   logic [31:0]          pc;
   logic [31:0]          rs1_value;
   logic                 ext_intr;
   logic                 software_intr;
   logic                 timer_intr;
   logic                 done;
   logic                 trap_taken;
   logic [31:0]          next_pc;
   logic [31:0]          rd_data;
   logic                 write_rd;
   logic [1:0]           priv_mode;

   // one entry per case line, stimulus then expected results
   logic [31:0] q_instr[$], q_pc[$], q_rs1[$], q_ext[$], q_soft[$], q_timer[$];
   logic [31:0] q_trap[$], q_next_pc[$], q_rd_data[$], q_write_rd[$], q_mode[$];

   int value_errors = 0;
   int other_errors = 0;
   int case_count = 0;
   int current_case = 0;
   int cycle_count = 0;
   int cycle_limit = 1000;

   priv_unit priv_unit_inst (
      .clk(clk), .rstn(rstn), .instr_valid(instr_valid), .instr(instr), .pc(pc),
      .rs1_value(rs1_value), .ext_intr(ext_intr), .software_intr(software_intr),
      .timer_intr(timer_intr), .done(done), .trap_taken(trap_taken), .next_pc(next_pc),
      .rd_data(rd_data), .write_rd(write_rd), .priv_mode(priv_mode)
   );

   always #2 clk = ~clk;

   // run limit
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles, the run did not finish", cycle_count);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////
   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL %0t case %0d %s: got %h expected %h", $time, current_case, name, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %0t case %0d %s: got %b expected %b", $time, current_case, name, got, exp);
         value_errors++;
      end
   endtask

   task automatic check_mode(input string name, input logic [1:0] got, input logic [1:0] exp);
      if (got !== exp) begin
         $display("FAIL %0t case %0d %s: got %0d expected %0d", $time, current_case, name, got, exp);
         value_errors++;
      end
   endtask

   ////////////////////////////////////////
   // case file
   ////////////////////////////////////////
   task automatic load_cases();
      int fd;
      int n;
      int r;
      string line;
      logic [31:0] c_instr, c_pc, c_rs1, c_ext, c_soft, c_timer;
      logic [31:0] c_trap, c_next_pc, c_rd_data, c_write_rd, c_mode;
      fd = $fopen("priv_cases.txt", "r");
      if (fd == 0) begin
         $display("could not open priv_cases.txt for reading");
         other_errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            // lines starting with # are comments
            if (r > 0 && line.len() > 0 && line[0] != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", c_instr, c_pc, c_rs1,
                           c_ext, c_soft, c_timer, c_trap, c_next_pc, c_rd_data,
                           c_write_rd, c_mode);
               if (n == 11) begin
                  q_instr.push_back(c_instr);
                  q_pc.push_back(c_pc);
                  q_rs1.push_back(c_rs1);
                  q_ext.push_back(c_ext);
                  q_soft.push_back(c_soft);
                  q_timer.push_back(c_timer);
                  q_trap.push_back(c_trap);
                  q_next_pc.push_back(c_next_pc);
                  q_rd_data.push_back(c_rd_data);
                  q_write_rd.push_back(c_write_rd);
                  q_mode.push_back(c_mode);
               end
            end
         end
         $fclose(fd);
      end
      case_count = q_instr.size();
   endtask

   // strobe one instruction, check one cycle later
   task automatic run_case(input int idx);
      @(posedge clk);
      instr.raw     <= q_instr[idx];
      pc            <= q_pc[idx];
      rs1_value     <= q_rs1[idx];
      ext_intr      <= q_ext[idx][0];
      software_intr <= q_soft[idx][0];
      timer_intr    <= q_timer[idx][0];
      instr_valid   <= 1'b1;
      @(posedge clk);
      instr_valid <= 1'b0;
      @(negedge clk);
      current_case = idx;
      if (done !== 1'b1) begin
         $display("case %0d: done did not pulse in the cycle after the strobe", idx);
         other_errors++;
      end else begin
         check_flag("trap_taken", trap_taken, q_trap[idx][0]);
         check_word("next_pc", next_pc, q_next_pc[idx]);
         check_word("rd_data", rd_data, q_rd_data[idx]);
         check_flag("write_rd", write_rd, q_write_rd[idx][0]);
         check_mode("priv_mode", priv_mode, q_mode[idx][1:0]);
      end
   endtask

   initial begin
      clk           = 1'b0;
      rstn          = 1'b1;
      instr_valid   = 1'b0;
      instr.raw     = 32'd0;
      pc            = 32'd0;
      rs1_value     = 32'd0;
      ext_intr      = 1'b0;
      software_intr = 1'b0;
      timer_intr    = 1'b0;
      load_cases();
      if (case_count == 0) begin
         $display("no cases were read from priv_cases.txt");
         other_errors++;
      end
      cycle_limit = 16 + 2 * case_count + 20;
      // reset is active high on rstn
      repeat (16) @(posedge clk);
      rstn <= 1'b0;
      for (int i = 0; i < case_count; i++) begin
         run_case(i);
      end
      $display("%0d cases, %0d value errors, %0d other errors",
               case_count, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== priv_cases.txt ====
# instr pc rs1_value ext_intr software_intr timer_intr (all hex)
# then expected trap_taken next_pc rd_data write_rd priv_mode (all hex)
# csr read/write, mcycle reads at cases 0 and 3
b00020f3 00001000 00000000 0 0 0 0 00001004 00000001 1 3
340110f3 00001004 a5a50f0f 0 0 0 0 00001008 00000000 1 3
340120f3 00001008 0000f0f0 0 0 0 0 0000100c a5a50f0f 1 3
b00020f3 0000100c 00000000 0 0 0 0 00001010 00000007 1 3
340ff0f3 00001010 00000000 0 0 0 0 00001014 a5a5ffff 1 3
3401e0f3 00001014 00000000 0 0 0 0 00001018 a5a5ffe0 1 3
34013073 00001018 a5a50000 0 0 0 0 0000101c a5a5ffe3 0 3
340020f3 0000101c 00000000 0 0 0 0 00001020 0000ffe3 1 3
# write masking
300110f3 00001020 ffffffff 0 0 0 0 00001024 00000000 1 3
300110f3 00001024 00000800 0 0 0 0 00001028 00001888 1 3
300020f3 00001028 00000000 0 0 0 0 0000102c 00000000 1 3
304110f3 0000102c ffffffff 0 0 0 0 00001030 00000000 1 3
341110f3 00001030 00002003 0 0 0 0 00001034 00000000 1 3
304020f3 00001034 00000000 0 0 0 0 00001038 00000888 1 3
341020f3 00001038 00000000 0 0 0 0 0000103c 00002000 1 3
305110f3 0000103c 00000302 0 0 0 0 00001040 00000100 1 3
301110f3 00001040 ffffffff 0 0 0 1 00000100 00000000 0 3
# exceptions
342020f3 00001044 00000000 0 0 0 0 00001048 00000002 1 3
343020f3 00001048 00000000 0 0 0 0 0000104c 301110f3 1 3
123020f3 0000104c 00000000 0 0 0 1 00000100 00000000 0 3
341020f3 00001050 00000000 0 0 0 0 00001054 0000104c 1 3
00004073 00001054 00000000 0 0 0 1 00000100 00000000 0 3
00100073 00001058 00000000 0 0 0 1 00000100 00000000 0 3
342020f3 0000105c 00000000 0 0 0 0 00001060 00000003 1 3
00000073 00001060 00000000 0 0 0 1 00000100 00000000 0 3
342020f3 00001064 00000000 0 0 0 0 00001068 0000000b 1 3
343020f3 00001068 00000000 0 0 0 0 0000106c 00000000 1 3
# mret and user mode
300130f3 0000106c 00001800 0 0 0 0 00001070 00001800 1 3
341110f3 00001070 00004000 0 0 0 0 00001074 00001060 1 3
30200073 00001074 00000000 0 0 0 0 00004000 00000000 0 0
340020f3 00004000 00000000 0 0 0 1 00000100 00000000 0 3
30200073 00000104 00000000 0 0 0 0 00004000 00000000 0 0
00000073 00004004 00000000 0 0 0 1 00000100 00000000 0 3
342020f3 00000104 00000000 0 0 0 0 00000108 00000008 1 3
# interrupts with vectored mtvec
305110f3 00000108 00000201 0 0 0 0 0000010c 00000100 1 3
10500073 0000010c 00000000 0 0 1 0 00000110 00000000 0 3
300460f3 00000110 00000000 0 0 1 0 00000114 00000000 1 3
10500073 00000114 00000000 0 0 1 1 0000021c 00000000 0 3
342020f3 0000021c 00000000 0 0 0 0 00000220 80000007 1 3
300130f3 00000220 00001880 0 0 0 0 00000224 00001880 1 3
341110f3 00000224 00005000 0 0 0 0 00000228 00000114 1 3
30200073 00000228 00000000 0 0 0 0 00005000 00000000 0 0
10500073 00005000 00000000 1 0 1 1 0000022c 00000000 0 3
342020f3 0000022c 00000000 0 0 0 0 00000230 8000000b 1 3

// ==== sources.f ====
+incdir+.
priv_pkg.sv
sys_decoder.sv
csr_file.sv
priv_ctrl.sv
priv_unit.sv
tb_priv_unit.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_priv_unit
FILELIST  = sources.f

SOURCES = $(shell grep -v '^+' $(FILELIST)) priv_consts.svh
BIN     = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) priv_cases.txt
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q '^TEST RESULT: PASS$$'

clean:
	rm -rf obj_dir
